// ==== hdl/hps_io_pkg.sv ====
//////////////////////////////////////////////////
// host control channel definitions
//////////////////////////////////////////////////

package hps_io_pkg;

	//////////////////////////////////////////////////
	// bus and payload types
	//////////////////////////////////////////////////

	// host to fpga word bus, one word per strobe
	typedef struct packed {
		logic        strobe;
		logic        io_enable;
		logic        fp_enable;
		logic [15:0] din;
	} hps_bus_t;

	// reply and payload word
	typedef logic [15:0] io_word_t;

	// joystick buttons, two words per load
	typedef logic [31:0] joy_t;

	// core status, eight words per load
	typedef logic [127:0] status_t;

	//////////////////////////////////////////////////
	// user-io commands
	//////////////////////////////////////////////////

	localparam logic [7:0] CMD_JOY0       = 8'h02;
	localparam logic [7:0] CMD_JOY1       = 8'h03;
	localparam logic [7:0] CMD_STATUS     = 8'h1e;
	localparam logic [7:0] CMD_STATUS_REQ = 8'h29;

	//////////////////////////////////////////////////
	// file-io commands
	//////////////////////////////////////////////////

	// transfer start and stop
	localparam logic [7:0] FIO_FILE_TX     = 8'h53;
	// download data, one byte per word
	localparam logic [7:0] FIO_FILE_TX_DAT = 8'h54;
	localparam logic [7:0] FIO_FILE_INDEX  = 8'h55;

	// upper nibble of the status request flag word
	localparam logic [3:0] STFLG_TAG = 4'hA;

	// transfer start value the host uses for an upload
	localparam logic [7:0] UPLOAD_MARK = 8'hAA;

endpackage

// ==== hdl/word_assembler.sv ====
//////////////////////////////////////////////////
// indexed word assembler
//////////////////////////////////////////////////

`timescale 1ns/1ps

module word_assembler
	import hps_io_pkg::*;
#(
	parameter type payload_t = joy_t
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       load,
	input  logic [3:0] index,
	input  io_word_t   word,
	output payload_t   payload
);

	// number of 16-bit slices in the payload
	localparam int N_SLICE = $bits(payload_t) / 16;

	logic [$bits(payload_t)-1:0] slices;
	logic                        index_ok;

	// indices past the last slice are dropped
	assign index_ok = (int'(index) < N_SLICE);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			slices <= '0;
		end else if (load && index_ok) begin
			slices[16*index +: 16] <= word;
		end
	end

	assign payload = payload_t'(slices);

endmodule

// ==== hdl/uio_decoder.sv ====
//////////////////////////////////////////////////
// user-io command decoder
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uio_decoder
	import hps_io_pkg::*;
(
	input  logic     clk_sys,
	input  logic     arst_n,
	input  hps_bus_t bus,
	input  status_t  status_in,
	input  logic     status_set,
	output io_word_t reply,
	output joy_t     joystick_0,
	output joy_t     joystick_1,
	output status_t  status
);

	io_word_t   cmd;
	logic [3:0] word_cnt;
	logic [3:0] pay_idx;
	logic       pay_strobe;

	// status request capture
	logic       status_set_q;
	logic [3:0] stflg;
	status_t    status_req;
	logic       req_word;

	//////////////////////////////////////////////////
	// frame tracking
	//////////////////////////////////////////////////

	// word 0 is the command, payload word 1 lands on slice 0
	assign pay_strobe = bus.strobe && bus.io_enable && (word_cnt != 4'd0);
	assign pay_idx    = word_cnt - 4'd1;

	// 29 returns eight request words after the flag word
	assign req_word = (word_cnt != 4'd0) && (word_cnt <= 4'd8);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cmd      <= '0;
			word_cnt <= '0;
			reply    <= '0;
		end else if (!bus.io_enable) begin
			cmd      <= '0;
			word_cnt <= '0;
			reply    <= '0;
		end else if (bus.strobe) begin
			reply <= '0;
			if (word_cnt != 4'hf)
				word_cnt <= word_cnt + 4'd1;
			if (word_cnt == 4'd0) begin
				cmd <= bus.din;
				if (bus.din == io_word_t'(CMD_STATUS_REQ))
					reply <= {STFLG_TAG, 8'h00, stflg};
			end else if (cmd == io_word_t'(CMD_STATUS_REQ) && req_word) begin
				reply <= status_req[16*pay_idx[2:0] +: 16];
			end
		end
	end

	//////////////////////////////////////////////////
	// status request edge and flag counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			status_set_q <= 1'b0;
			stflg        <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q)
				stflg <= stflg + 4'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_q)
			status_req <= status_in;
	end

	//////////////////////////////////////////////////
	// payload assemblers
	//////////////////////////////////////////////////

	word_assembler #(.payload_t(joy_t)) joy0_asm_i (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.load    (pay_strobe && cmd == io_word_t'(CMD_JOY0)),
		.index   (pay_idx),
		.word    (bus.din),
		.payload (joystick_0)
	);

	word_assembler #(.payload_t(joy_t)) joy1_asm_i (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.load    (pay_strobe && cmd == io_word_t'(CMD_JOY1)),
		.index   (pay_idx),
		.word    (bus.din),
		.payload (joystick_1)
	);

	word_assembler #(.payload_t(status_t)) status_asm_i (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.load    (pay_strobe && cmd == io_word_t'(CMD_STATUS)),
		.index   (pay_idx),
		.word    (bus.din),
		.payload (status)
	);

endmodule

// ==== hdl/fio_loader.sv ====
//////////////////////////////////////////////////
// file-io download loader
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fio_loader
	import hps_io_pkg::*;
#(
	parameter int ADDR_W = 27
) (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  hps_bus_t          bus,
	output io_word_t          reply,
	output logic              ioctl_download,
	output io_word_t          ioctl_index,
	output logic              ioctl_wr,
	output logic [ADDR_W-1:0] ioctl_addr,
	output logic [7:0]        ioctl_dout
);

	io_word_t          cmd;
	logic              has_cmd;
	logic [1:0]        word_cnt;
	logic [ADDR_W-1:0] addr;
	logic              fp_strobe;

	// first write stage
	logic              wr_q;
	logic [ADDR_W-1:0] addr_q;
	logic [7:0]        dat_q;

	assign fp_strobe = bus.strobe && bus.fp_enable;

	// no read path, the host only downloads
	assign reply = '0;

	//////////////////////////////////////////////////
	// command and transfer state
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cmd            <= '0;
			has_cmd        <= 1'b0;
			word_cnt       <= '0;
			addr           <= '0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			wr_q           <= 1'b0;
		end else begin
			wr_q <= 1'b0;
			if (!bus.fp_enable) begin
				has_cmd <= 1'b0;
			end else if (fp_strobe && !has_cmd) begin
				cmd      <= bus.din;
				has_cmd  <= 1'b1;
				word_cnt <= '0;
			end else if (fp_strobe) begin
				if (word_cnt != 2'd3)
					word_cnt <= word_cnt + 2'd1;
				case (cmd)
					io_word_t'(FIO_FILE_INDEX): ioctl_index <= bus.din;
					io_word_t'(FIO_FILE_TX): begin
						case (word_cnt)
							2'd0: begin
								// an upload request is left alone
								if (bus.din[7:0] == 8'h00) begin
									ioctl_download <= 1'b0;
								end else if (bus.din[7:0] != UPLOAD_MARK) begin
									ioctl_download <= 1'b1;
									addr           <= '0;
								end
							end
							2'd1: addr[15:0] <= bus.din;
							// upper bits above 16, truncated to the address width
							2'd2: addr <= ADDR_W'({bus.din, addr[15:0]});
							default: ;
						endcase
					end
					io_word_t'(FIO_FILE_TX_DAT): begin
						if (ioctl_download) begin
							wr_q <= 1'b1;
							addr <= addr + 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// two stage write pulse
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (fp_strobe && has_cmd) begin
			addr_q <= addr;
			dat_q  <= bus.din[7:0];
		end
		if (wr_q)
			ioctl_dout <= dat_q;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_wr   <= 1'b0;
			ioctl_addr <= '0;
		end else begin
			ioctl_wr <= wr_q;
			if (wr_q)
				ioctl_addr <= addr_q;
		end
	end

endmodule

// ==== hdl/hps_io_lite.sv ====
//////////////////////////////////////////////////
// host io control channel
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hps_io_lite
	import hps_io_pkg::*;
#(
	parameter int ADDR_W = 27
) (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  hps_bus_t          bus,
	output io_word_t          dout,
	output logic              bus_wait,
	input  status_t           status_in,
	input  logic              status_set,
	input  logic              ioctl_wait,
	output joy_t              joystick_0,
	output joy_t              joystick_1,
	output status_t           status,
	output logic              ioctl_download,
	output io_word_t          ioctl_index,
	output logic              ioctl_wr,
	output logic [ADDR_W-1:0] ioctl_addr,
	output logic [7:0]        ioctl_dout
);

	io_word_t uio_reply;
	io_word_t fio_reply;

	uio_decoder uio_decoder_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.bus        (bus),
		.status_in  (status_in),
		.status_set (status_set),
		.reply      (uio_reply),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status)
	);

	fio_loader #(.ADDR_W(ADDR_W)) fio_loader_i (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.bus            (bus),
		.reply          (fio_reply),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	// file-io frames answer from the loader
	assign dout = bus.fp_enable ? fio_reply : uio_reply;

	// the core pauses the host directly
	assign bus_wait = ioctl_wait;

endmodule

// ==== dv/clk_gen.sv ====
//////////////////////////////////////////////////
// testbench clock and reset
//////////////////////////////////////////////////

`timescale 1ns/1ps

module clk_gen #(
	parameter real PERIOD_NS  = 8.0,
	parameter int  RST_CYCLES = 10
) (
	output logic clk_sys,
	output logic arst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_sys = ~clk_sys;
	end

	// reset released on a rising edge
	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_sys);
		arst_n <= 1'b1;
	end

endmodule

// ==== dv/hps_io_lite_assertions.sv ====
//////////////////////////////////////////////////
// bound protocol assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hps_io_lite_assertions
	import hps_io_pkg::*;
(
	input logic     clk_sys,
	input logic     arst_n,
	input hps_bus_t bus,
	input logic     ioctl_wr,
	input logic     ioctl_download
);

	// write strobe is a single cycle pulse
	wr_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wr |=> !ioctl_wr)
		else $error("ioctl_wr high for two cycles in a row");

	enable_excl: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(bus.io_enable && bus.fp_enable))
		else $error("io_enable and fp_enable high together");

	// writes only belong to a download
	wr_in_download: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wr |-> ioctl_download)
		else $error("ioctl_wr outside a download");

endmodule

bind hps_io_lite hps_io_lite_assertions hps_io_lite_assertions_i (
	.clk_sys        (clk_sys),
	.arst_n         (arst_n),
	.bus            (bus),
	.ioctl_wr       (ioctl_wr),
	.ioctl_download (ioctl_download)
);

// ==== dv/hps_io_lite_tb.sv ====
//////////////////////////////////////////////////
// host io channel testbench
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hps_io_lite_tb
	import hps_io_pkg::*;
;

	localparam int ADDR_W  = 27;
	localparam int N_BYTES = 40;
	localparam int TIMEOUT = 200;

	logic              clk_sys;
	logic              arst_n;
	hps_bus_t          bus;
	io_word_t          dout;
	logic              bus_wait;
	status_t           status_in;
	logic              status_set;
	logic              ioctl_wait;
	joy_t              joystick_0;
	joy_t              joystick_1;
	status_t           status;
	logic              ioctl_download;
	io_word_t          ioctl_index;
	logic              ioctl_wr;
	logic [ADDR_W-1:0] ioctl_addr;
	logic [7:0]        ioctl_dout;

	// payload words to send, and replies seen after each strobe
	io_word_t    pay [64];
	io_word_t    rep [16];
	int          value_errs = 0;
	int          other_errs = 0;
	int          wr_cnt = 0;
	logic        stall_en = 1'b0;
	logic [31:0] rng = 32'h350e_4df5;

	clk_gen clk_gen_i (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	hps_io_lite #(.ADDR_W(ADDR_W)) hps_io_lite_i (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.bus            (bus),
		.dout           (dout),
		.bus_wait       (bus_wait),
		.status_in      (status_in),
		.status_set     (status_set),
		.ioctl_wait     (ioctl_wait),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.status         (status),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// one strobe then one idle cycle
	// during downloads the core may stall the host first
	task automatic send_word(input io_word_t w);
		int t;
		rng = xorshift(rng);
		if (stall_en && rng[1:0] == 2'd0) begin
			ioctl_wait <= 1'b1;
			repeat (int'(rng[3:2]) + 1) begin
				@(posedge clk_sys);
				check("bus_wait during stall", bus_wait, 1'b1);
			end
			ioctl_wait <= 1'b0;
		end
		t = 0;
		while (bus_wait && t < TIMEOUT) begin
			@(posedge clk_sys);
			t++;
		end
		if (bus_wait) begin
			other_errs++;
			$display("timeout at %0t ns: bus_wait never dropped", $time);
		end else begin
			bus.strobe <= 1'b1;
			bus.din    <= w;
			@(posedge clk_sys);
			bus.strobe <= 1'b0;
			@(posedge clk_sys);
		end
	endtask

	task automatic uio_frame(input io_word_t cmd, input int n);
		bus.io_enable <= 1'b1;
		@(posedge clk_sys);
		send_word(cmd);
		rep[0] = dout;
		for (int i = 0; i < n; i++) begin
			send_word(pay[i]);
			rep[i + 1] = dout;
		end
		bus.io_enable <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic fio_frame(input io_word_t cmd, input int n);
		bus.fp_enable <= 1'b1;
		@(posedge clk_sys);
		send_word(cmd);
		for (int i = 0; i < n; i++)
			send_word(pay[i]);
		bus.fp_enable <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	// write monitor and host back-pressure rule
	always @(posedge clk_sys) begin
		check("strobe while bus_wait high", bus.strobe && bus_wait, 1'b0);
		if (ioctl_wr && wr_cnt < 64) begin
			check("ioctl_addr", ioctl_addr, wr_cnt);
			check("ioctl_dout", ioctl_dout, pay[wr_cnt][7:0]);
			wr_cnt <= wr_cnt + 1;
		end
	end

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_reset_state();
		check("joystick_0 after reset", joystick_0, 0);
		check("joystick_1 after reset", joystick_1, 0);
		check("status after reset", status, 0);
		check("ioctl_download after reset", ioctl_download, 0);
		check("ioctl_wr after reset", ioctl_wr, 0);
		check("ioctl_index after reset", ioctl_index, 0);
		check("ioctl_addr after reset", ioctl_addr, 0);
		check("dout after reset", dout, 0);
	endtask

	task automatic test_joysticks();
		joy_t j0;
		joy_t j1;
		rng = xorshift(rng);
		pay[0] = rng[15:0];
		pay[1] = rng[31:16];
		j0 = {pay[1], pay[0]};
		uio_frame(io_word_t'(CMD_JOY0), 2);
		check("joystick_0", joystick_0, j0);
		rng = xorshift(rng);
		pay[0] = rng[15:0];
		pay[1] = rng[31:16];
		j1 = {pay[1], pay[0]};
		uio_frame(io_word_t'(CMD_JOY1), 2);
		check("joystick_1", joystick_1, j1);
		check("joystick_0 kept", joystick_0, j0);
		pay[0] = 16'hdead;
		pay[1] = 16'hbeef;
		// 07 is no known command
		uio_frame(16'h0007, 2);
		check("joystick_0 after unknown", joystick_0, j0);
		check("joystick_1 after unknown", joystick_1, j1);
	endtask

	task automatic test_status();
		status_t exp;
		for (int i = 0; i < 8; i++) begin
			rng = xorshift(rng);
			pay[i] = rng[15:0];
			exp[16*i +: 16] = rng[15:0];
		end
		uio_frame(io_word_t'(CMD_STATUS), 8);
		check("status", status, exp);
	endtask

	task automatic test_status_request();
		status_t v;
		for (int i = 0; i < 4; i++) begin
			rng = xorshift(rng);
			v[32*i +: 32] = rng;
		end
		status_in <= v;
		for (int k = 0; k < 3; k++) begin
			status_set <= 1'b1;
			@(posedge clk_sys);
			status_set <= 1'b0;
			@(posedge clk_sys);
		end
		for (int i = 0; i < 8; i++)
			pay[i] = '0;
		uio_frame(io_word_t'(CMD_STATUS_REQ), 8);
		check("flag word tag", rep[0][15:12], 4'hA);
		check("flag word count", rep[0][3:0], 4'd3);
		for (int i = 0; i < 8; i++)
			check("status request word", rep[i + 1], v[16*i +: 16]);
	endtask

	task automatic test_download();
		io_word_t idx;
		int       t;
		rng = xorshift(rng);
		idx = rng[15:0];
		pay[0] = idx;
		fio_frame(io_word_t'(FIO_FILE_INDEX), 1);
		check("ioctl_index", ioctl_index, idx);
		pay[0] = 16'h00ff;
		fio_frame(io_word_t'(FIO_FILE_TX), 1);
		check("ioctl_download after start", ioctl_download, 1'b1);
		for (int i = 0; i < N_BYTES; i++) begin
			rng = xorshift(rng);
			pay[i] = rng[15:0];
		end
		stall_en = 1'b1;
		fio_frame(io_word_t'(FIO_FILE_TX_DAT), N_BYTES);
		stall_en = 1'b0;
		t = 0;
		while (wr_cnt < N_BYTES && t < TIMEOUT) begin
			@(posedge clk_sys);
			t++;
		end
		if (wr_cnt < N_BYTES) begin
			other_errs++;
			$display("timeout at %0t ns: only %0d of %0d writes seen", $time, wr_cnt, N_BYTES);
		end
		// late extra pulses would show up here
		repeat (4) @(posedge clk_sys);
		check("ioctl_wr pulse count", wr_cnt, N_BYTES);
		pay[0] = 16'h0000;
		fio_frame(io_word_t'(FIO_FILE_TX), 1);
		check("ioctl_download after stop", ioctl_download, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// sequence
	//////////////////////////////////////////////////

	initial begin
		int t;
		bus        = '0;
		status_in  = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		t = 0;
		while (!arst_n && t < TIMEOUT) begin
			@(posedge clk_sys);
			t++;
		end
		if (!arst_n) begin
			other_errs++;
			$display("timeout: reset was never released");
		end
		@(posedge clk_sys);
		test_reset_state();
		test_joysticks();
		test_status();
		test_status_request();
		test_download();
		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== hps_io_lite.f ====
hdl/hps_io_pkg.sv
hdl/word_assembler.sv
hdl/uio_decoder.sv
hdl/fio_loader.sv
hdl/hps_io_lite.sv
dv/clk_gen.sv
dv/hps_io_lite_assertions.sv
dv/hps_io_lite_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, result judged from sim.log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module hps_io_lite_tb \
	-f hps_io_lite.f -o sim > build.log 2>&1 \
	&& ./obj_dir/sim > sim.log 2>&1 \
	|| echo "Checks failed" >> sim.log
cat build.log sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0
